//--- decode_stage.f
common/decode_pkg.sv
hdl/fetch_slicer.sv
decoder/instr_decoder.sv
hdl/group_collector.sv
hdl/decode_stage_top.sv
tests/tb_clock_gen.sv
tests/decode_stage_properties.sv
tests/tb_decode_stage.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_decode_stage -f decode_stage.f -o sim_decode_stage

out=$(./obj_dir/sim_decode_stage)
echo "$out"

if echo "$out" | grep -q "TESTS PASSED"; then
	exit 0
fi
exit 1

//--- tests/tb_decode_stage.sv
`timescale 1ns/10ps

module tb_decode_stage;

	localparam int NS = 4;
	typedef decode_pkg::dec_slot_t [NS-1:0] group_t;

	localparam logic [2:0]  LD_F3 [5]  = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
	localparam logic [2:0]  BR_F3 [6]  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
	localparam logic [2:0]  CSR_F3 [6] = '{3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7};
	localparam logic [11:0] PRIV [6]   = '{12'h000, 12'h001, 12'h002, 12'h102, 12'h302, 12'h105};

	logic              i_clk, i_arst_n, i_flush, i_exception_pending, i_fetch_valid;
	logic [31:0]       i_fetch_pc;
	logic [NS*32-1:0]  i_fetch_packet;
	logic              o_group_valid;
	group_t            o_group_slots;
	logic [2:0]        o_group_count;

	logic [31:0] lfsr;
	int          cycle = 0;
	int          mismatches = 0;
	int          other_errors = 0;
	group_t      exp_q[$];
	int          exp_cnt_q[$];
	int          exp_cyc_q[$]; // cycle the group must show up

	tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(16)) u_clk (.o_clk(i_clk), .o_arst_n(i_arst_n));

	decode_stage_top #(.NUM_SLOTS(NS)) UUT (
		.i_clk               (i_clk),
		.i_arst_n            (i_arst_n),
		.i_flush             (i_flush),
		.i_exception_pending (i_exception_pending),
		.i_fetch_valid       (i_fetch_valid),
		.i_fetch_pc          (i_fetch_pc),
		.i_fetch_packet      (i_fetch_packet),
		.o_group_valid       (o_group_valid),
		.o_group_slots       (o_group_slots),
		.o_group_count       (o_group_count)
	);

	always @(posedge i_clk) cycle <= cycle + 1;

	// galois lfsr, one step per bit
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [31:0] gen_instr();
		logic [31:0] w;
		logic [31:0] r;
		r = rand_bits(4);
		w = rand_bits(32); // random fields, opcode and functs fixed below
		case (r[3:0])
			4'd0, 4'd14: begin
				w[6:0] = decode_pkg::OPC_OP;
				w[31:25] = ((w[14:12] == 3'd0 || w[14:12] == 3'd5) && w[25]) ? 7'h20 : 7'h00;
			end
			4'd1: begin
				w[6:0] = decode_pkg::OPC_OP;
				w[31:25] = 7'h01; // mul/div
			end
			4'd2, 4'd15: begin
				w[6:0] = decode_pkg::OPC_OP_IMM;
				if (w[14:12] == 3'd1) w[31:25] = 7'h00;
				else if (w[14:12] == 3'd5) w[31:25] = w[30] ? 7'h20 : 7'h00;
			end
			4'd3: begin
				w[6:0] = decode_pkg::OPC_LOAD;
				w[14:12] = LD_F3[w[31:20] % 5];
			end
			4'd4: begin
				w[6:0] = decode_pkg::OPC_STORE;
				w[14:12] = LD_F3[w[31:20] % 3];
			end
			4'd5: begin
				w[6:0] = decode_pkg::OPC_BRANCH;
				w[14:12] = BR_F3[w[31:20] % 6];
			end
			4'd6: w[6:0] = decode_pkg::OPC_JAL;
			4'd7: begin
				w[6:0] = decode_pkg::OPC_JALR;
				w[14:12] = 3'd0;
			end
			4'd8: w[6:0] = decode_pkg::OPC_LUI;
			4'd9: w[6:0] = decode_pkg::OPC_AUIPC;
			4'd10: w = {PRIV[w[31:20] % 6], 13'h0, decode_pkg::OPC_SYSTEM}; // traps, returns, wfi
			4'd11: begin
				w[6:0] = decode_pkg::OPC_SYSTEM;
				w[14:12] = CSR_F3[w[31:20] % 6];
			end
			4'd12: ; // raw word
			default: begin
				if (w[31]) w[6:0] = 7'b0001111; // fence
				else w[1:0] = 2'b01;            // compressed
			end
		endcase
		return w;
	endfunction

	// expected decode of one word, straight from the isa tables
	function automatic decode_pkg::dec_slot_t ref_decode(logic [31:0] w, logic [31:0] pc,
			logic vld, logic exc);
		decode_pkg::dec_slot_t s;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] imm_i;
		logic        ok;
		s = '0;
		s.valid = vld;
		s.pc = pc;
		f3 = w[14:12];
		f7 = w[31:25];
		imm_i = {{20{w[31]}}, w[31:20]};
		ok = 1'b0;
		case (w[6:0])
			decode_pkg::OPC_OP: begin
				if (f7 == 7'h01) begin
					ok = 1'b1;
					s.ctrl.fn = decode_pkg::FN_MULDIV;
					case (f3)
						3'd0: s.ctrl.muldiv_op = decode_pkg::MD_MUL;
						3'd1: s.ctrl.muldiv_op = decode_pkg::MD_MULH;
						3'd2: s.ctrl.muldiv_op = decode_pkg::MD_MULHSU;
						3'd3: s.ctrl.muldiv_op = decode_pkg::MD_MULHU;
						3'd4: s.ctrl.muldiv_op = decode_pkg::MD_DIV;
						3'd5: s.ctrl.muldiv_op = decode_pkg::MD_DIVU;
						3'd6: s.ctrl.muldiv_op = decode_pkg::MD_REM;
						default: s.ctrl.muldiv_op = decode_pkg::MD_REMU;
					endcase
				end else if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
					ok = 1'b1;
					s.ctrl.alu_fn = {w[30], f3};
				end
				if (ok) begin
					s.ctrl.we = 1'b1;
					s.rd = w[11:7];
					s.rs1 = w[19:15];
					s.rs2 = w[24:20];
				end
			end
			decode_pkg::OPC_OP_IMM: begin
				ok = (f3 == 3'd1) ? (f7 == 7'h00) : (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
				if (ok) begin
					s.ctrl.we = 1'b1;
					s.ctrl.b_sel = (f3 == 3'd1 || f3 == 3'd5) ? 2'b10 : 2'b01; // shamt or imm
					s.ctrl.alu_fn = {w[30] && f3 == 3'd5, f3};
					s.rd = w[11:7];
					s.rs1 = w[19:15];
					s.imm = imm_i;
				end
			end
			decode_pkg::OPC_LOAD: begin
				ok = 1'b1;
				case (f3)
					3'd0: s.ctrl.mem_op = decode_pkg::MEM_LB;
					3'd1: s.ctrl.mem_op = decode_pkg::MEM_LH;
					3'd2: s.ctrl.mem_op = decode_pkg::MEM_LW;
					3'd4: s.ctrl.mem_op = decode_pkg::MEM_LBU;
					3'd5: s.ctrl.mem_op = decode_pkg::MEM_LHU;
					default: ok = 1'b0;
				endcase
				if (ok) begin
					s.ctrl.we = 1'b1;
					s.ctrl.b_sel = 2'b01;
					s.ctrl.fn = decode_pkg::FN_LOAD;
					s.rd = w[11:7];
					s.rs1 = w[19:15];
					s.imm = imm_i;
				end
			end
			decode_pkg::OPC_STORE: begin
				ok = 1'b1;
				case (f3)
					3'd0: s.ctrl.mem_op = decode_pkg::MEM_SB;
					3'd1: s.ctrl.mem_op = decode_pkg::MEM_SH;
					3'd2: s.ctrl.mem_op = decode_pkg::MEM_SW;
					default: ok = 1'b0;
				endcase
				if (ok) begin
					s.rs1 = w[19:15];
					s.rs2 = w[24:20];
					s.imm = {{20{w[31]}}, w[31:25], w[11:7]};
				end
			end
			decode_pkg::OPC_BRANCH: begin
				ok = (f3 != 3'd2 && f3 != 3'd3);
				if (ok) begin
					s.ctrl.btype = 1'b1;
					s.ctrl.bneq = (f3 == 3'd1);
					s.ctrl.pcselect = 2'b10;
					case (f3)
						3'd4: s.ctrl.alu_fn = 4'b0010;
						3'd5: s.ctrl.alu_fn = 4'b1001;
						3'd6: s.ctrl.alu_fn = 4'b0011;
						3'd7: s.ctrl.alu_fn = 4'b1010;
						default: s.ctrl.alu_fn = 4'b1000; // equality compare
					endcase
					s.rs1 = w[19:15];
					s.rs2 = w[24:20];
					s.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
				end
			end
			decode_pkg::OPC_JAL: begin
				ok = 1'b1;
				s.ctrl.j = 1'b1;
				s.ctrl.we = 1'b1;
				s.ctrl.fn = decode_pkg::FN_PC4;
				s.ctrl.pcselect = 2'b10;
				s.rd = w[11:7];
				s.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			end
			decode_pkg::OPC_JALR: begin
				ok = (f3 == 3'd0);
				if (ok) begin
					s.ctrl.jr = 1'b1;
					s.ctrl.we = 1'b1;
					s.ctrl.b_sel = 2'b01;
					s.ctrl.fn = decode_pkg::FN_PC4;
					s.ctrl.pcselect = 2'b10;
					s.rd = w[11:7];
					s.rs1 = w[19:15];
					s.imm = imm_i;
				end
			end
			decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC: begin
				ok = 1'b1;
				s.ctrl.we = 1'b1;
				s.ctrl.lui = w[5];    // lui has bit 5 set
				s.ctrl.auipc = !w[5];
				s.ctrl.fn = w[5] ? decode_pkg::FN_IMM : decode_pkg::FN_AUIPC;
				s.rd = w[11:7];
				s.imm = {w[31:12], 12'h000};
			end
			decode_pkg::OPC_SYSTEM: begin
				if (f3 == 3'd0) begin
					s.ctrl.ecall = (w[31:20] == 12'h000);
					s.ctrl.ebreak = (w[31:20] == 12'h001);
					s.ctrl.uret = (w[31:20] == 12'h002);
					s.ctrl.sret = (w[31:20] == 12'h102);
					s.ctrl.mret = (w[31:20] == 12'h302);
					s.ctrl.wfi = (w[31:20] == 12'h105);
					ok = s.ctrl.ecall | s.ctrl.ebreak | s.ctrl.uret | s.ctrl.sret
						| s.ctrl.mret | s.ctrl.wfi;
				end else begin
					ok = (f3 != 3'd4);
				end
				if (ok) begin
					s.ctrl.we = !exc; // held off while commit has a trap
					s.ctrl.csr_we = 1'b1;
					s.ctrl.fn = decode_pkg::FN_CSR;
					s.rd = w[11:7];
					s.rs1 = w[19:15];
					s.imm = imm_i;
				end
			end
			default: ok = 1'b0;
		endcase
		if (!ok) begin
			s = '0;
			s.valid = vld;
			s.pc = pc;
			s.ctrl.illegal = 1'b1;
		end
		return s;
	endfunction

	// slicer mask plus collector cut over a whole packet
	function automatic group_t ref_group(logic [NS*32-1:0] pkt, logic [31:0] pc, logic exc,
			output int cnt);
		group_t g;
		logic   stop;
		int     ofs;
		ofs = int'(pc[3:2]);
		stop = 1'b0;
		cnt = 0;
		for (int k = 0; k < NS; k++) begin
			g[k] = ref_decode(pkt[k*32 +: 32], {pc[31:4], 4'h0} + 32'(4 * k), k >= ofs, exc);
			if (g[k].valid && !stop) begin
				cnt++;
				stop = g[k].ctrl.btype | g[k].ctrl.j | g[k].ctrl.jr | g[k].ctrl.illegal
					| g[k].ctrl.ecall | g[k].ctrl.ebreak | g[k].ctrl.uret | g[k].ctrl.sret
					| g[k].ctrl.mret | g[k].ctrl.wfi | g[k].ctrl.csr_we;
			end else begin
				g[k].valid = 1'b0;
				g[k].ctrl = '0;
			end
		end
		return g;
	endfunction

	task automatic check_field(string name, int slot, logic [63:0] got, logic [63:0] exp);
		if (got !== exp) begin
			$display("MISMATCH slot%0d.%s got %h expected %h", slot, name, got, exp);
			mismatches++;
		end
	endtask

	// compare on the falling edge, away from register updates
	always @(negedge i_clk) begin
		group_t g;
		int     c;
		int     t;
		if (i_arst_n && o_group_valid) begin
			if (exp_q.size() == 0) begin
				$display("unexpected group presented at cycle %0d", cycle);
				other_errors++;
			end else begin
				g = exp_q.pop_front();
				c = exp_cnt_q.pop_front();
				t = exp_cyc_q.pop_front();
				if (t != cycle) begin
					$display("group came at cycle %0d instead of cycle %0d", cycle, t);
					other_errors++;
				end
				if (int'(o_group_count) != c) begin
					$display("MISMATCH o_group_count got %h expected %h", o_group_count, c);
					mismatches++;
				end
				for (int k = 0; k < NS; k++) begin
					check_field("valid", k, 64'(o_group_slots[k].valid), 64'(g[k].valid));
					check_field("pc", k, 64'(o_group_slots[k].pc), 64'(g[k].pc));
					check_field("rd", k, 64'(o_group_slots[k].rd), 64'(g[k].rd));
					check_field("rs1", k, 64'(o_group_slots[k].rs1), 64'(g[k].rs1));
					check_field("rs2", k, 64'(o_group_slots[k].rs2), 64'(g[k].rs2));
					check_field("imm", k, 64'(o_group_slots[k].imm), 64'(g[k].imm));
					check_field("ctrl", k, 64'(o_group_slots[k].ctrl), 64'(g[k].ctrl));
				end
			end
		end
	end

	// called just after a rising edge
	task automatic send_packet(logic [NS*32-1:0] pkt, logic [31:0] pc);
		int c;
		i_fetch_valid = 1'b1;
		i_fetch_pc = pc;
		i_fetch_packet = pkt;
		exp_q.push_back(ref_group(pkt, pc, i_exception_pending, c));
		exp_cnt_q.push_back(c);
		exp_cyc_q.push_back(cycle + 2); // sliced next cycle, presented the one after
		@(posedge i_clk);
		#2;
		i_fetch_valid = 1'b0;
	endtask

	task automatic idle_cycle();
		i_fetch_valid = 1'b0;
		@(posedge i_clk);
		#2;
	endtask

	task automatic send_random(int n);
		logic [NS*32-1:0] pkt;
		logic [31:0]      r;
		for (int i = 0; i < n; i++) begin
			r = rand_bits(3);
			if (r[2:0] == 3'd0) begin
				idle_cycle(); // a gap now and then
			end else begin
				for (int k = 0; k < NS; k++) pkt[k*32 +: 32] = gen_instr();
				r = rand_bits(30);
				send_packet(pkt, {r[29:0], 2'b00});
			end
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 20) begin
			@(posedge i_clk);
			#2;
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout: %0d expected groups never presented", exp_q.size());
			other_errors++;
			exp_q.delete();
			exp_cnt_q.delete();
			exp_cyc_q.delete();
		end
	endtask

	// last packet of a back to back run still sits in the slicer
	task automatic flush_pipe();
		i_fetch_valid = 1'b0;
		i_flush = 1'b1;
		@(posedge i_clk);
		#2;
		i_flush = 1'b0;
		for (int i = 0; i < 3; i++) idle_cycle();
		if (exp_q.size() != 1) begin
			$display("flush left %0d expected groups, wanted 1", exp_q.size());
			other_errors++;
		end
		exp_q.delete();
		exp_cnt_q.delete();
		exp_cyc_q.delete();
	endtask

	initial begin
		logic [NS*32-1:0] alu_pkt;
		int               n;
		i_flush = 1'b0;
		i_exception_pending = 1'b0;
		i_fetch_valid = 1'b0;
		i_fetch_pc = '0;
		i_fetch_packet = '0;
		lfsr = 32'd79146;
		alu_pkt = {32'h00b50533, 32'h40c585b3, 32'h02d606b3, 32'h00470713}; // add sub mul addi

		@(posedge i_clk); // reset is low by now
		n = 0;
		while (i_arst_n !== 1'b1 && n < 40) begin
			@(posedge i_clk);
			n++;
		end
		if (i_arst_n !== 1'b1) begin
			$display("timeout: reset never released");
			other_errors++;
		end
		@(posedge i_clk);
		#2;

		send_random(60);
		drain();
		i_exception_pending = 1'b1; // system write back held off
		send_random(40);
		drain();
		i_exception_pending = 1'b0;

		send_packet(alu_pkt, 32'h0000_1000); // full group of four
		send_packet(alu_pkt, 32'h0000_200c); // only the top slot
		send_packet(alu_pkt, 32'h0000_3008);
		drain();

		for (int i = 0; i < 3; i++) send_packet(alu_pkt, 32'h0000_4004);
		flush_pipe();

		send_random(30);
		drain();

		$display("errors: mismatches=%0d other=%0d", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- tests/decode_stage_properties.sv
`timescale 1ns/10ps

module decode_stage_properties #(
	parameter int NUM_SLOTS = 4
) (
	input logic                                  i_clk,
	input logic                                  i_arst_n,
	input logic                                  i_flush,
	input logic                                  i_fetch_valid,
	input logic                                  o_group_valid,
	input decode_pkg::dec_slot_t [NUM_SLOTS-1:0] o_group_slots,
	input logic [$clog2(NUM_SLOTS):0]            o_group_count
);

	logic [NUM_SLOTS-1:0] vbits;
	int                   runs; // number of separate valid runs

	always_comb begin
		runs = 0;
		for (int k = 0; k < NUM_SLOTS; k++) begin
			vbits[k] = o_group_slots[k].valid;
		end
		if (vbits[0]) runs = 1;
		for (int k = 1; k < NUM_SLOTS; k++) begin
			if (vbits[k] && !vbits[k-1]) runs = runs + 1; // start of a run
		end
	end

	a_quiet_in_reset: assert property (@(posedge i_clk) !i_arst_n |-> !o_group_valid)
		else $error("group valid while in reset");

	// two stage pipe, any flush in the window breaks the link
	a_two_cycle: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(!$past(i_flush) && !$past(i_flush, 2)) |-> (o_group_valid == $past(i_fetch_valid, 2)))
		else $error("group valid does not follow fetch valid by two cycles");

	a_contiguous: assert property (@(posedge i_clk) disable iff (!i_arst_n) runs <= 1)
		else $error("valid output slots not contiguous");

	a_count: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		int'(o_group_count) == $countones(vbits))
		else $error("group count differs from number of valid slots");

endmodule

bind decode_stage_top decode_stage_properties #(.NUM_SLOTS(NUM_SLOTS)) u_props (
	.i_clk         (i_clk),
	.i_arst_n      (i_arst_n),
	.i_flush       (i_flush),
	.i_fetch_valid (i_fetch_valid),
	.o_group_valid (o_group_valid),
	.o_group_slots (o_group_slots),
	.o_group_count (o_group_count)
);

//--- tests/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 16
) (
	output logic o_clk,
	output logic o_arst_n
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

	// reset drops just after time zero so the async edge is seen
	initial begin
		o_arst_n = 1'b1;
		#1 o_arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		#1 o_arst_n = 1'b1;
	end

endmodule

//--- hdl/decode_stage_top.sv
`timescale 1ns/10ps

module decode_stage_top #(
	parameter int NUM_SLOTS = 4
) (
	input  logic                                   i_clk,
	input  logic                                   i_arst_n,
	input  logic                                   i_flush,
	input  logic                                   i_exception_pending,
	input  logic                                   i_fetch_valid,
	input  logic [decode_pkg::XLEN-1:0]            i_fetch_pc,
	input  logic [NUM_SLOTS*32-1:0]                i_fetch_packet,
	output logic                                   o_group_valid,
	output decode_pkg::dec_slot_t [NUM_SLOTS-1:0]  o_group_slots,
	output logic [$clog2(NUM_SLOTS):0]             o_group_count
);

	decode_pkg::fetch_slot_t [NUM_SLOTS-1:0] fetch_slots; // stage 1 out
	decode_pkg::dec_slot_t   [NUM_SLOTS-1:0] dec_slots;   // comb decode out

	fetch_slicer #(
		.NUM_SLOTS (NUM_SLOTS)
	) u_slicer (
		.i_clk          (i_clk),
		.i_arst_n       (i_arst_n),
		.i_flush        (i_flush),
		.i_fetch_valid  (i_fetch_valid),
		.i_fetch_pc     (i_fetch_pc),
		.i_fetch_packet (i_fetch_packet),
		.o_slots        (fetch_slots)
	);

	// one decoder per slot
	for (genvar k = 0; k < NUM_SLOTS; k++) begin : g_dec
		instr_decoder u_dec (
			.i_slot              (fetch_slots[k]),
			.i_exception_pending (i_exception_pending), // unregistered
			.o_slot              (dec_slots[k])
		);
	end

	group_collector #(
		.NUM_SLOTS (NUM_SLOTS)
	) u_collector (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_flush       (i_flush),
		.i_slots       (dec_slots),
		.o_group_valid (o_group_valid),
		.o_group_slots (o_group_slots),
		.o_group_count (o_group_count)
	);

endmodule

//--- hdl/group_collector.sv
`timescale 1ns/10ps

module group_collector #(
	parameter int NUM_SLOTS = 4
) (
	input  logic                                   i_clk,
	input  logic                                   i_arst_n,
	input  logic                                   i_flush,
	input  decode_pkg::dec_slot_t [NUM_SLOTS-1:0]  i_slots,
	output logic                                   o_group_valid,
	output decode_pkg::dec_slot_t [NUM_SLOTS-1:0]  o_group_slots,
	output logic [$clog2(NUM_SLOTS):0]             o_group_count
);

	localparam int CNT_W = $clog2(NUM_SLOTS) + 1;

	logic [NUM_SLOTS-1:0]                  keep;      // slot survives the cut
	logic                                  any_valid;
	logic                                  stop;      // running, set by a sequence ender
	logic [CNT_W-1:0]                      cnt;
	decode_pkg::dec_ctrl_t [NUM_SLOTS-1:0] c;

	logic                                  grp_valid_q;
	logic [NUM_SLOTS-1:0]                  vld_q;
	logic [CNT_W-1:0]                      cnt_q;
	decode_pkg::dec_slot_t [NUM_SLOTS-1:0] slots_q;

	// scan from slot 0 up, the ender itself stays in
	always_comb begin
		stop      = 1'b0;
		any_valid = 1'b0;
		cnt       = '0;
		for (int k = 0; k < NUM_SLOTS; k++) begin
			c[k]      = i_slots[k].ctrl;
			any_valid = any_valid | i_slots[k].valid;
			keep[k]   = i_slots[k].valid & ~stop;
			if (keep[k]) begin
				cnt = cnt + CNT_W'(1);
				stop = c[k].btype | c[k].j | c[k].jr | c[k].illegal
					| c[k].ecall | c[k].ebreak | c[k].uret | c[k].sret
					| c[k].mret | c[k].wfi | c[k].csr_we;
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			grp_valid_q <= 1'b0;
			vld_q       <= '0;
			cnt_q       <= '0;
		end else if (i_flush) begin
			grp_valid_q <= 1'b0; // group in flight is dropped
			vld_q       <= '0;
			cnt_q       <= '0;
		end else begin
			grp_valid_q <= any_valid;
			vld_q       <= keep;
			cnt_q       <= cnt;
		end
	end

	always_ff @(posedge i_clk) begin
		slots_q <= i_slots; // payload, qualified by vld_q
	end

	always_comb begin
		for (int k = 0; k < NUM_SLOTS; k++) begin
			o_group_slots[k]       = slots_q[k];
			o_group_slots[k].valid = vld_q[k];
			if (!vld_q[k]) begin
				o_group_slots[k].ctrl = '0; // dead slot carries no control
			end
		end
	end

	assign o_group_valid = grp_valid_q;
	assign o_group_count = cnt_q;

endmodule

//--- decoder/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
	input  decode_pkg::fetch_slot_t i_slot,
	input  logic                    i_exception_pending, // level from commit
	output decode_pkg::dec_slot_t   o_slot
);

	decode_pkg::instr_word_u iw;
	decode_pkg::dec_ctrl_t   ctrl;

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [11:0] funct12;
	logic        instr_30;

	// opcode classes
	logic is_op, is_op_imm, is_load, is_store, is_branch;
	logic is_jal, is_jalr, is_lui, is_auipc, is_system;

	// funct7 patterns
	logic f7_zero, f7_alt, f7_mul;

	// legal subsets of each class
	logic alu_r, muldiv, op_imm_ok, shift_imm, load_ok, store_ok;
	logic branch_ok, jalr_ok, sys_priv, sys_csr, system_ok, legal;
	logic ecall, ebreak, uret, sret, mret, wfi;

	// which format the word uses
	logic fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j;

	assign iw       = i_slot.instr;
	assign opcode   = iw.r.opcode;
	assign funct3   = iw.r.funct3;
	assign funct7   = iw.r.funct7;
	assign funct12  = iw.i.imm;
	assign instr_30 = iw.raw[30]; // sub / sra / srai

	assign is_op     = (opcode == decode_pkg::OPC_OP);
	assign is_op_imm = (opcode == decode_pkg::OPC_OP_IMM);
	assign is_load   = (opcode == decode_pkg::OPC_LOAD);
	assign is_store  = (opcode == decode_pkg::OPC_STORE);
	assign is_branch = (opcode == decode_pkg::OPC_BRANCH);
	assign is_jal    = (opcode == decode_pkg::OPC_JAL);
	assign is_jalr   = (opcode == decode_pkg::OPC_JALR);
	assign is_lui    = (opcode == decode_pkg::OPC_LUI);
	assign is_auipc  = (opcode == decode_pkg::OPC_AUIPC);
	assign is_system = (opcode == decode_pkg::OPC_SYSTEM);

	assign f7_zero = (funct7 == 7'b0000000);
	assign f7_alt  = (funct7 == 7'b0100000);
	assign f7_mul  = (funct7 == 7'b0000001); // M extension

	// alt funct7 only on sub and sra
	assign alu_r  = is_op & (f7_zero | (f7_alt & (funct3 == 3'b000 | funct3 == 3'b101)));
	assign muldiv = is_op & f7_mul;

	assign shift_imm = op_imm_ok & (funct3 == 3'b001 | funct3 == 3'b101);
	assign op_imm_ok = is_op_imm & (
		(funct3 == 3'b001) ? f7_zero :            // slli
		(funct3 == 3'b101) ? (f7_zero | f7_alt) : // srli, srai
		1'b1);

	assign load_ok   = is_load & (funct3 != 3'b011) & (funct3[2:1] != 2'b11);
	assign store_ok  = is_store & (funct3[2] == 1'b0) & (funct3 != 3'b011);
	assign branch_ok = is_branch & (funct3[2:1] != 2'b01);
	assign jalr_ok   = is_jalr & (funct3 == 3'b000);

	// privileged ops are told apart by funct12
	assign sys_priv = is_system & (funct3 == 3'b000);
	assign sys_csr  = is_system & (funct3 != 3'b000) & (funct3 != 3'b100);
	assign ecall    = sys_priv & (funct12 == 12'h000);
	assign ebreak   = sys_priv & (funct12 == 12'h001);
	assign uret     = sys_priv & (funct12 == 12'h002);
	assign sret     = sys_priv & (funct12 == 12'h102);
	assign mret     = sys_priv & (funct12 == 12'h302);
	assign wfi      = sys_priv & (funct12 == 12'h105);
	assign system_ok = sys_csr | ecall | ebreak | uret | sret | mret | wfi;

	// fence, compressed and anything unknown fall out here
	assign legal = alu_r | muldiv | op_imm_ok | load_ok | store_ok | branch_ok
		| is_jal | jalr_ok | is_lui | is_auipc | system_ok;

	assign fmt_r = alu_r | muldiv;
	assign fmt_i = op_imm_ok | load_ok | jalr_ok | system_ok;
	assign fmt_s = store_ok;
	assign fmt_b = branch_ok;
	assign fmt_u = is_lui | is_auipc;
	assign fmt_j = is_jal;

	always_comb begin
		ctrl = '0;
		ctrl.illegal = ~legal;
		ctrl.we      = fmt_r | op_imm_ok | load_ok | is_jal | jalr_ok | fmt_u
			| (system_ok & ~i_exception_pending); // no csr write back under a trap
		ctrl.csr_we  = system_ok; // traps and returns update status csrs too
		ctrl.b_sel   = {shift_imm, (op_imm_ok & ~shift_imm) | jalr_ok | load_ok};
		ctrl.j       = is_jal;
		ctrl.jr      = jalr_ok;
		ctrl.btype   = branch_ok;
		ctrl.bneq    = branch_ok & (funct3 == 3'b001);
		ctrl.lui     = is_lui;
		ctrl.auipc   = is_auipc;
		ctrl.pcselect = {branch_ok | is_jal | jalr_ok, 1'b0};
		ctrl.ecall   = ecall;
		ctrl.ebreak  = ebreak;
		ctrl.uret    = uret;
		ctrl.sret    = sret;
		ctrl.mret    = mret;
		ctrl.wfi     = wfi;

		// result source
		if (muldiv)                 ctrl.fn = decode_pkg::FN_MULDIV;
		else if (load_ok)           ctrl.fn = decode_pkg::FN_LOAD;
		else if (is_jal | jalr_ok)  ctrl.fn = decode_pkg::FN_PC4; // link address
		else if (is_lui)            ctrl.fn = decode_pkg::FN_IMM;
		else if (is_auipc)          ctrl.fn = decode_pkg::FN_AUIPC;
		else if (system_ok)         ctrl.fn = decode_pkg::FN_CSR;
		else                        ctrl.fn = decode_pkg::FN_ALU;

		// alu op, branches reuse the comparator codes
		if (alu_r) begin
			ctrl.alu_fn = {instr_30, funct3};
		end else if (op_imm_ok) begin
			ctrl.alu_fn = {instr_30 & (funct3 == 3'b101), funct3}; // only srai keeps bit 30
		end else if (branch_ok) begin
			case (funct3)
				3'b100:  ctrl.alu_fn = 4'b0010; // blt
				3'b101:  ctrl.alu_fn = 4'b1001; // bge
				3'b110:  ctrl.alu_fn = 4'b0011; // bltu
				3'b111:  ctrl.alu_fn = 4'b1010; // bgeu
				default: ctrl.alu_fn = 4'b1000; // beq, bne
			endcase
		end

		if (load_ok) begin
			case (funct3)
				3'b000:  ctrl.mem_op = decode_pkg::MEM_LB;
				3'b001:  ctrl.mem_op = decode_pkg::MEM_LH;
				3'b010:  ctrl.mem_op = decode_pkg::MEM_LW;
				3'b100:  ctrl.mem_op = decode_pkg::MEM_LBU;
				3'b101:  ctrl.mem_op = decode_pkg::MEM_LHU;
				default: ctrl.mem_op = decode_pkg::MEM_NONE;
			endcase
		end else if (store_ok) begin
			case (funct3)
				3'b000:  ctrl.mem_op = decode_pkg::MEM_SB;
				3'b001:  ctrl.mem_op = decode_pkg::MEM_SH;
				3'b010:  ctrl.mem_op = decode_pkg::MEM_SW;
				default: ctrl.mem_op = decode_pkg::MEM_NONE;
			endcase
		end

		if (muldiv) begin
			case (funct3)
				3'b000:  ctrl.muldiv_op = decode_pkg::MD_MUL;
				3'b001:  ctrl.muldiv_op = decode_pkg::MD_MULH;
				3'b010:  ctrl.muldiv_op = decode_pkg::MD_MULHSU;
				3'b011:  ctrl.muldiv_op = decode_pkg::MD_MULHU;
				3'b100:  ctrl.muldiv_op = decode_pkg::MD_DIV;
				3'b101:  ctrl.muldiv_op = decode_pkg::MD_DIVU;
				3'b110:  ctrl.muldiv_op = decode_pkg::MD_REM;
				default: ctrl.muldiv_op = decode_pkg::MD_REMU;
			endcase
		end else begin
			ctrl.muldiv_op = decode_pkg::MD_NONE;
		end
	end

	always_comb begin
		o_slot       = '0;
		o_slot.valid = i_slot.valid;
		o_slot.pc    = i_slot.pc;
		o_slot.ctrl  = ctrl;

		// indices only where the format has them
		if (fmt_r | fmt_i | fmt_u | fmt_j) o_slot.rd  = iw.r.rd;
		if (fmt_r | fmt_i | fmt_s | fmt_b) o_slot.rs1 = iw.r.rs1;
		if (fmt_r | fmt_s | fmt_b)         o_slot.rs2 = iw.r.rs2;

		// immediate from the matching view of the word
		if (fmt_i) begin
			o_slot.imm = {{20{iw.i.imm[11]}}, iw.i.imm};
		end else if (fmt_s) begin
			o_slot.imm = {{20{iw.s.imm_11_5[6]}}, iw.s.imm_11_5, iw.s.imm_4_0};
		end else if (fmt_b) begin
			o_slot.imm = {{19{iw.b.imm_12}}, iw.b.imm_12, iw.b.imm_11,
				iw.b.imm_10_5, iw.b.imm_4_1, 1'b0};
		end else if (fmt_u) begin
			o_slot.imm = {iw.u.imm_31_12, 12'b0};
		end else if (fmt_j) begin
			o_slot.imm = {{11{iw.j.imm_20}}, iw.j.imm_20, iw.j.imm_19_12,
				iw.j.imm_11, iw.j.imm_10_1, 1'b0};
		end
	end

endmodule

//--- hdl/fetch_slicer.sv
`timescale 1ns/10ps

module fetch_slicer #(
	parameter int NUM_SLOTS = 4
) (
	input  logic                                     i_clk,
	input  logic                                     i_arst_n,
	input  logic                                     i_flush,
	input  logic                                     i_fetch_valid,
	input  logic [decode_pkg::XLEN-1:0]              i_fetch_pc,
	input  logic [NUM_SLOTS*32-1:0]                  i_fetch_packet,
	output decode_pkg::fetch_slot_t [NUM_SLOTS-1:0]  o_slots
);

	localparam int OFS_W = $clog2(NUM_SLOTS); // word index bits inside a packet
	localparam int LSB_W = OFS_W + 2;         // byte offset bits of a packet

	logic                          pkt_valid_q;
	logic [decode_pkg::XLEN-1:0]   pc_q;
	logic [NUM_SLOTS*32-1:0]       packet_q;

	logic [OFS_W-1:0]              start_ofs;
	logic [decode_pkg::XLEN-1:0]   base_pc;

	// packet valid, flush wins over a new packet
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pkt_valid_q <= 1'b0;
		end else if (i_flush) begin
			pkt_valid_q <= 1'b0;
		end else begin
			pkt_valid_q <= i_fetch_valid;
		end
	end

	// payload only moves on a new packet
	always_ff @(posedge i_clk) begin
		if (i_fetch_valid) begin
			pc_q     <= i_fetch_pc;
			packet_q <= i_fetch_packet;
		end
	end

	assign start_ofs = pc_q[LSB_W-1:2];                    // first wanted word
	assign base_pc   = {pc_q[decode_pkg::XLEN-1:LSB_W], LSB_W'(0)}; // packet aligned

	always_comb begin
		for (int k = 0; k < NUM_SLOTS; k++) begin
			o_slots[k].valid     = pkt_valid_q & (k >= int'(start_ofs)); // skip words before pc
			o_slots[k].pc        = base_pc + decode_pkg::XLEN'(4 * k);
			o_slots[k].instr.raw = packet_q[k*32 +: 32]; // slot 0 in low word
		end
	end

endmodule

//--- common/decode_pkg.sv
package decode_pkg;

	parameter int XLEN = 32;

	// instruction formats, msb first as in the isa manual
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm; // also funct12 for system ops
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one word, six views
	typedef union packed {
		logic [31:0] raw;
		r_fmt_t      r;
		i_fmt_t      i;
		s_fmt_t      s;
		b_fmt_t      b;
		u_fmt_t      u;
		j_fmt_t      j;
	} instr_word_u;

	typedef struct packed {
		logic [1:0] b_sel;     // op b select, 01 imm, 10 shamt
		logic       we;        // rd write back
		logic [2:0] fn;        // result select, FN_*
		logic [3:0] alu_fn;    // {bit30, funct3} style
		logic       j;
		logic       jr;
		logic       bneq;
		logic       btype;
		logic       lui;
		logic       auipc;
		logic [3:0] mem_op;    // MEM_*
		logic [3:0] muldiv_op; // MD_*
		logic [1:0] pcselect;
		logic       ecall;
		logic       ebreak;
		logic       uret;
		logic       sret;
		logic       mret;
		logic       wfi;
		logic       illegal;
		logic       csr_we;
	} dec_ctrl_t;

	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc;
		logic [4:0]      rd;
		logic [4:0]      rs1;
		logic [4:0]      rs2;
		logic [XLEN-1:0] imm;  // sign extended
		dec_ctrl_t       ctrl;
	} dec_slot_t;

	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc;
		instr_word_u     instr;
	} fetch_slot_t;

	// major opcodes
	parameter logic [6:0] OPC_OP     = 7'b0110011;
	parameter logic [6:0] OPC_OP_IMM = 7'b0010011;
	parameter logic [6:0] OPC_LOAD   = 7'b0000011;
	parameter logic [6:0] OPC_STORE  = 7'b0100011;
	parameter logic [6:0] OPC_BRANCH = 7'b1100011;
	parameter logic [6:0] OPC_JAL    = 7'b1101111;
	parameter logic [6:0] OPC_JALR   = 7'b1100111;
	parameter logic [6:0] OPC_LUI    = 7'b0110111;
	parameter logic [6:0] OPC_AUIPC  = 7'b0010111;
	parameter logic [6:0] OPC_SYSTEM = 7'b1110011;

	// mem_op: [3] store, [2:1] size (11 w, 01 h, 10 b), [0] signed
	parameter logic [3:0] MEM_NONE = 4'b0000;
	parameter logic [3:0] MEM_SW   = 4'b1111;
	parameter logic [3:0] MEM_SH   = 4'b1011;
	parameter logic [3:0] MEM_SB   = 4'b1101;
	parameter logic [3:0] MEM_LW   = 4'b0111;
	parameter logic [3:0] MEM_LH   = 4'b0011;
	parameter logic [3:0] MEM_LHU  = 4'b0010;
	parameter logic [3:0] MEM_LB   = 4'b0101;
	parameter logic [3:0] MEM_LBU  = 4'b0100;

	// muldiv_op: [3] div/rem, [2] high half or rem, [1:0] signedness
	parameter logic [3:0] MD_NONE   = 4'b0000;
	parameter logic [3:0] MD_MUL    = 4'b0011;
	parameter logic [3:0] MD_MULH   = 4'b0101;
	parameter logic [3:0] MD_MULHU  = 4'b0111;
	parameter logic [3:0] MD_MULHSU = 4'b0110;
	parameter logic [3:0] MD_DIV    = 4'b1001;
	parameter logic [3:0] MD_DIVU   = 4'b1011;
	parameter logic [3:0] MD_REM    = 4'b1101;
	parameter logic [3:0] MD_REMU   = 4'b1111;

	// write back source
	parameter logic [2:0] FN_ALU    = 3'b000;
	parameter logic [2:0] FN_PC4    = 3'b001;
	parameter logic [2:0] FN_MULDIV = 3'b010;
	parameter logic [2:0] FN_IMM    = 3'b011;
	parameter logic [2:0] FN_AUIPC  = 3'b100;
	parameter logic [2:0] FN_CSR    = 3'b110; // csr read data
	parameter logic [2:0] FN_LOAD   = 3'b111;

endpackage
